// File: fetch_config.svh
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// Fetch stage sizing
////////////////////////////////////////////////////////////////////////////

// Address and instruction width
`define FETCH_XLEN 32

// Cache lines, one word each, power of two
`define ICACHE_LINES 16

// Predictor entries, power of two
`define BHT_ENTRIES 16

// First fetch address after reset
`define RESET_VECTOR 32'h0000_0000

`endif

// File: fetchPkg.sv
`include "fetch_config.svh"

package fetchPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Vector types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [`FETCH_XLEN-1:0] addrT;
    typedef logic [`FETCH_XLEN-1:0] instrT;

    // Saturating counter, 2 and 3 predict taken
    typedef logic [1:0] ctrT;

    // Word index into the cache and the predictor
    typedef logic [$clog2(`ICACHE_LINES)-1:0] cacheIdxT;
    typedef logic [$clog2(`BHT_ENTRIES)-1:0] bhtIdxT;

    // Address bits above the cache index, byte bits dropped
    typedef logic [`FETCH_XLEN-$clog2(`ICACHE_LINES)-3:0] tagT;

    ////////////////////////////////////////////////////////////////////////////
    // Refill FSM
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        refillIdle,
        refillRequest,
        refillWrite
    } refillStateT;

endpackage

// File: pcUnit.sv
`timescale 1ns/1ps
`include "fetch_config.svh"

module pcUnit (
    input  logic           Clk,
    input  logic           rstN,
    input  logic           flushPipeAndPc,
    input  fetchPkg::addrT redirectAddr,
    input  logic           advance,
    input  logic           predictTaken,
    input  fetchPkg::addrT predictTarget,
    output fetchPkg::addrT fetchAddr
);

    fetchPkg::addrT nextAddr;
    fetchPkg::addrT seqAddr;

    assign seqAddr = fetchAddr + fetchPkg::addrT'(4);

    ////////////////////////////////////////////////////////////////////////////
    // Next-address select
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        if (flushPipeAndPc) begin
            // Branch unit always wins
            nextAddr = redirectAddr;
        end else if (advance && predictTaken) begin
            nextAddr = predictTarget;
        end else if (advance) begin
            nextAddr = seqAddr;
        end else begin
            // Miss or stall
            nextAddr = fetchAddr;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Fetch address register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            fetchAddr <= `RESET_VECTOR;
        end else begin
            fetchAddr <= nextAddr;
        end
    end

    // Redirects and stored targets must keep the PC on word boundaries
    pcAligned: assert property (@(posedge Clk) disable iff (!rstN)
        fetchAddr[1:0] == 2'b00);

endmodule

// File: branchPredictor.sv
`timescale 1ns/1ps
`include "fetch_config.svh"

module branchPredictor (
    input  logic           Clk,
    input  logic           rstN,
    input  fetchPkg::addrT fetchAddr,
    input  logic           resolveValid,
    input  logic           resolveTaken,
    input  fetchPkg::addrT resolvePc,
    input  fetchPkg::addrT resolveTarget,
    output logic           predictTaken,
    output fetchPkg::addrT predictTarget,
    output fetchPkg::ctrT  predictCtr
);

    localparam int IdxW = $clog2(`BHT_ENTRIES);
    localparam int TagW = `FETCH_XLEN - IdxW - 2;

    logic [`BHT_ENTRIES-1:0] entryValid;
    logic [TagW-1:0]         tagMem    [`BHT_ENTRIES];
    fetchPkg::addrT          targetMem [`BHT_ENTRIES];
    fetchPkg::ctrT           ctrMem    [`BHT_ENTRIES];

    fetchPkg::bhtIdxT rdIdx;
    fetchPkg::bhtIdxT wrIdx;
    logic [TagW-1:0]  rdTag;
    logic [TagW-1:0]  wrTag;
    logic             rdMatch;
    logic             wrMatch;
    fetchPkg::ctrT    wrCtr;
    fetchPkg::ctrT    nextCtr;

    // Word address bits pick the entry
    assign rdIdx = fetchAddr[IdxW+1:2];
    assign rdTag = fetchAddr[`FETCH_XLEN-1:IdxW+2];
    assign wrIdx = resolvePc[IdxW+1:2];
    assign wrTag = resolvePc[`FETCH_XLEN-1:IdxW+2];

    ////////////////////////////////////////////////////////////////////////////
    // Lookup
    ////////////////////////////////////////////////////////////////////////////

    assign rdMatch       = entryValid[rdIdx] && (tagMem[rdIdx] == rdTag);
    assign predictCtr    = ctrMem[rdIdx];
    assign predictTaken  = rdMatch && predictCtr[1];
    assign predictTarget = targetMem[rdIdx];

    ////////////////////////////////////////////////////////////////////////////
    // Update on resolve
    ////////////////////////////////////////////////////////////////////////////

    assign wrMatch = entryValid[wrIdx] && (tagMem[wrIdx] == wrTag);
    assign wrCtr   = ctrMem[wrIdx];

    always_comb begin
        if (!wrMatch) begin
            // Fresh entry starts weak in the resolved direction
            nextCtr = resolveTaken ? 2'd2 : 2'd1;
        end else if (resolveTaken) begin
            nextCtr = (wrCtr == 2'd3) ? wrCtr : wrCtr + 2'd1;
        end else begin
            nextCtr = (wrCtr == 2'd0) ? wrCtr : wrCtr - 2'd1;
        end
    end

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            entryValid <= '0;
            for (int i = 0; i < `BHT_ENTRIES; i++) begin
                ctrMem[i] <= 2'd1;
            end
        end else if (resolveValid) begin
            entryValid[wrIdx] <= 1'b1;
            ctrMem[wrIdx]     <= nextCtr;
        end
    end

    // Target refreshed on allocation and on every taken outcome
    always_ff @(posedge Clk) begin
        if (resolveValid && (!wrMatch || resolveTaken)) begin
            tagMem[wrIdx]    <= wrTag;
            targetMem[wrIdx] <= resolveTarget;
        end
    end

endmodule

// File: instrCache.sv
`timescale 1ns/1ps
`include "fetch_config.svh"

module instrCache (
    input  logic            Clk,
    input  logic            rstN,
    input  fetchPkg::addrT  fetchAddr,
    input  logic            fillEn,
    input  fetchPkg::addrT  fillAddr,
    input  fetchPkg::instrT fillData,
    output logic            hit,
    output fetchPkg::instrT hitInstr
);

    localparam int IdxW = $clog2(`ICACHE_LINES);

    // One word per line
    logic [`ICACHE_LINES-1:0] lineValid;
    fetchPkg::tagT            tagMem  [`ICACHE_LINES];
    fetchPkg::instrT          dataMem [`ICACHE_LINES];

    fetchPkg::cacheIdxT rdIdx;
    fetchPkg::cacheIdxT wrIdx;
    fetchPkg::tagT      rdTag;
    fetchPkg::tagT      wrTag;

    assign rdIdx = fetchAddr[IdxW+1:2];
    assign rdTag = fetchAddr[`FETCH_XLEN-1:IdxW+2];
    assign wrIdx = fillAddr[IdxW+1:2];
    assign wrTag = fillAddr[`FETCH_XLEN-1:IdxW+2];

    ////////////////////////////////////////////////////////////////////////////
    // Read side, combinational
    ////////////////////////////////////////////////////////////////////////////

    assign hit      = lineValid[rdIdx] && (tagMem[rdIdx] == rdTag);
    assign hitInstr = dataMem[rdIdx];

    ////////////////////////////////////////////////////////////////////////////
    // Fill side
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            lineValid <= '0;
        end else if (fillEn) begin
            lineValid[wrIdx] <= 1'b1;
        end
    end

    always_ff @(posedge Clk) begin
        if (fillEn) begin
            tagMem[wrIdx]  <= wrTag;
            dataMem[wrIdx] <= fillData;
        end
    end

endmodule

// File: refillCtrl.sv
`timescale 1ns/1ps
`include "fetch_config.svh"

module refillCtrl (
    input  logic            Clk,
    input  logic            rstN,
    input  fetchPkg::addrT  fetchAddr,
    input  logic            hit,
    input  logic            memValid,
    input  fetchPkg::instrT memData,
    output logic            memReq,
    output fetchPkg::addrT  memAddr,
    output logic            fillEn,
    output fetchPkg::addrT  fillAddr,
    output fetchPkg::instrT fillData,
    output logic            iMiss
);

    fetchPkg::refillStateT state;
    fetchPkg::refillStateT nextState;

    ////////////////////////////////////////////////////////////////////////////
    // Refill FSM
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        nextState = state;
        case (state)
            fetchPkg::refillIdle: begin
                if (!hit) begin
                    nextState = fetchPkg::refillRequest;
                end
            end
            fetchPkg::refillRequest: begin
                // Wait for the memory answer
                if (memValid) begin
                    nextState = fetchPkg::refillWrite;
                end
            end
            fetchPkg::refillWrite: begin
                nextState = fetchPkg::refillIdle;
            end
            default: begin
                nextState = fetchPkg::refillIdle;
            end
        endcase
    end

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            state <= fetchPkg::refillIdle;
        end else begin
            state <= nextState;
        end
    end

    // Missing address held for the whole request
    always_ff @(posedge Clk) begin
        if (state == fetchPkg::refillIdle && !hit) begin
            memAddr <= fetchAddr;
        end
        if (state == fetchPkg::refillRequest && memValid) begin
            fillData <= memData;
        end
    end

    assign memReq   = (state == fetchPkg::refillRequest);
    assign fillEn   = (state == fetchPkg::refillWrite);
    assign fillAddr = memAddr;
    assign iMiss    = !hit;

    // Memory sees one steady request until it answers
    reqStable: assert property (@(posedge Clk) disable iff (!rstN)
        memReq && !memValid |=> memReq && $stable(memAddr));

endmodule

// File: ifIdReg.sv
`timescale 1ns/1ps
`include "fetch_config.svh"

module ifIdReg (
    input  logic            Clk,
    input  logic            rstN,
    input  logic            ifIdStall,
    input  logic            ifIdFlush,
    input  fetchPkg::instrT inInstr,
    input  fetchPkg::addrT  inAddr,
    input  logic            inValid,
    input  logic            inPredict,
    input  fetchPkg::ctrT   inCtr,
    output fetchPkg::instrT ir,
    output fetchPkg::addrT  instrAddr,
    output logic            fetchValid,
    output logic            predictTaken,
    output fetchPkg::ctrT   predictCtr,
    output fetchPkg::addrT  pc
);

    // Flush beats stall
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            ir           <= '0;
            instrAddr    <= '0;
            fetchValid   <= 1'b0;
            predictTaken <= 1'b0;
            predictCtr   <= '0;
            pc           <= '0;
        end else if (ifIdFlush) begin
            ir           <= '0;
            instrAddr    <= '0;
            fetchValid   <= 1'b0;
            predictTaken <= 1'b0;
            predictCtr   <= '0;
            pc           <= '0;
        end else if (!ifIdStall) begin
            ir           <= inInstr;
            instrAddr    <= inAddr;
            fetchValid   <= inValid;
            predictTaken <= inPredict;
            predictCtr   <= inCtr;
            pc           <= inAddr + fetchPkg::addrT'(4);
        end
    end

endmodule

// File: fetchStage.sv
`timescale 1ns/1ps
`include "fetch_config.svh"

module fetchStage (
    input  logic            Clk,
    input  logic            rstN,
    // Branch unit
    input  logic            flushPipeAndPc,
    input  fetchPkg::addrT  redirectAddr,
    input  logic            resolveValid,
    input  fetchPkg::addrT  resolvePc,
    input  logic            resolveTaken,
    input  fetchPkg::addrT  resolveTarget,
    // Stall unit
    input  logic            pcStall,
    input  logic            ifIdStall,
    input  logic            ifIdFlush,
    output logic            iMiss,
    // Memory port
    output logic            memReq,
    output fetchPkg::addrT  memAddr,
    input  logic            memValid,
    input  fetchPkg::instrT memData,
    // To decode
    output fetchPkg::instrT ir,
    output fetchPkg::addrT  pc,
    output fetchPkg::addrT  instrAddr,
    output logic            predictTaken,
    output fetchPkg::ctrT   predictCtr,
    output logic            fetchValid
);

    fetchPkg::addrT  fetchAddr;
    logic            hit;
    fetchPkg::instrT hitInstr;
    logic            bpTaken;
    fetchPkg::addrT  bpTarget;
    fetchPkg::ctrT   bpCtr;
    logic            fillEn;
    fetchPkg::addrT  fillAddr;
    fetchPkg::instrT fillData;
    logic            advance;
    logic            inValid;

    // PC only moves on a word that is actually there
    assign advance = hit && !pcStall;

    // A redirect drops whatever was fetched this cycle
    assign inValid = hit && !pcStall && !flushPipeAndPc;

    pcUnit pcUnitInst (
        .Clk           (Clk),
        .rstN          (rstN),
        .flushPipeAndPc(flushPipeAndPc),
        .redirectAddr  (redirectAddr),
        .advance       (advance),
        .predictTaken  (bpTaken),
        .predictTarget (bpTarget),
        .fetchAddr     (fetchAddr)
    );

    branchPredictor bhtInst (
        .Clk          (Clk),
        .rstN         (rstN),
        .fetchAddr    (fetchAddr),
        .resolveValid (resolveValid),
        .resolveTaken (resolveTaken),
        .resolvePc    (resolvePc),
        .resolveTarget(resolveTarget),
        .predictTaken (bpTaken),
        .predictTarget(bpTarget),
        .predictCtr   (bpCtr)
    );

    instrCache icacheInst (
        .Clk      (Clk),
        .rstN     (rstN),
        .fetchAddr(fetchAddr),
        .fillEn   (fillEn),
        .fillAddr (fillAddr),
        .fillData (fillData),
        .hit      (hit),
        .hitInstr (hitInstr)
    );

    refillCtrl refillInst (
        .Clk      (Clk),
        .rstN     (rstN),
        .fetchAddr(fetchAddr),
        .hit      (hit),
        .memValid (memValid),
        .memData  (memData),
        .memReq   (memReq),
        .memAddr  (memAddr),
        .fillEn   (fillEn),
        .fillAddr (fillAddr),
        .fillData (fillData),
        .iMiss    (iMiss)
    );

    ifIdReg ifIdInst (
        .Clk         (Clk),
        .rstN        (rstN),
        .ifIdStall   (ifIdStall),
        .ifIdFlush   (ifIdFlush),
        .inInstr     (hitInstr),
        .inAddr      (fetchAddr),
        .inValid     (inValid),
        .inPredict   (bpTaken),
        .inCtr       (bpCtr),
        .ir          (ir),
        .instrAddr   (instrAddr),
        .fetchValid  (fetchValid),
        .predictTaken(predictTaken),
        .predictCtr  (predictCtr),
        .pc          (pc)
    );

    // Holding IF/ID while the PC runs on would lose an instruction
    stallPairing: assert property (@(posedge Clk) disable iff (!rstN)
        ifIdStall |-> pcStall);

endmodule

// File: fetchStageTb.sv
`timescale 1ns/1ps
`include "fetch_config.svh"

module fetchStageTb;

    localparam int RandomCycles   = 600;
    localparam int DrainOutputs   = 40;
    localparam int WorstMissDelay = 6;
    // Every test cycle may cost twice a worst-case miss
    localparam int TimeoutCycles  = (RandomCycles + DrainOutputs) * 2 * WorstMissDelay;
    // Small code region so lines get reused and evicted
    localparam int AddrWords      = 24;
    localparam int TestRead       = 0;
    localparam int TestMiss       = 1;
    localparam int TestPredict    = 2;
    localparam int TestRedirect   = 3;
    localparam int TestStall      = 4;
    localparam int TestFlush      = 5;

    logic            Clk;
    logic            rstN;
    logic            flushPipeAndPc;
    fetchPkg::addrT  redirectAddr;
    logic            resolveValid;
    fetchPkg::addrT  resolvePc;
    logic            resolveTaken;
    fetchPkg::addrT  resolveTarget;
    logic            pcStall;
    logic            ifIdStall;
    logic            ifIdFlush;
    logic            iMiss;
    logic            memReq;
    fetchPkg::addrT  memAddr;
    logic            memValid;
    fetchPkg::instrT memData;
    fetchPkg::instrT ir;
    fetchPkg::addrT  pc;
    fetchPkg::addrT  instrAddr;
    logic            predictTaken;
    fetchPkg::ctrT   predictCtr;
    logic            fetchValid;

    // Reference state for the predictor and the cache contents
    logic            bhtValid  [`BHT_ENTRIES];
    fetchPkg::addrT  bhtPc     [`BHT_ENTRIES];
    fetchPkg::addrT  bhtTarget [`BHT_ENTRIES];
    fetchPkg::ctrT   bhtCtr    [`BHT_ENTRIES];
    logic            cacheValid[`ICACHE_LINES];
    fetchPkg::addrT  cacheAddr [`ICACHE_LINES];

    int              seed;
    int              iter = 0;
    int              drained = 0;
    int              memWait = 0;
    int              cycleCount = 0;
    int              totalChk = 0;
    int              totalErr = 0;
    int              chkCnt [6];
    int              errCnt [6];
    string           testName [6] = '{"readback", "miss", "predict", "redirect", "stall",
                                      "flush"};
    fetchPkg::addrT  expectNext = `RESET_VECTOR;
    int              expectSrc = TestRead;

    // Inputs as driven one iteration back
    logic            stallPrev = 1'b0;
    logic            flushPrev = 1'b0;
    logic            redirPrev = 1'b0;
    fetchPkg::addrT  redirPrevAddr = '0;
    logic            resPrev = 1'b0;
    fetchPkg::addrT  resPrevPc = '0;
    logic            resPrevTaken = 1'b0;
    fetchPkg::addrT  resPrevTarget = '0;
    logic            missPrev = 1'b0;
    logic            reqPrev = 1'b0;
    logic [99:0]     lastOut = '0;

    fetchStage UUT (.*);

    always #4 Clk = ~Clk;

    always @(posedge Clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            $display("Timeout after %0d cycles, fetch stopped making progress", cycleCount);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic fetchPkg::instrT memWord(fetchPkg::addrT a);
        return (a * 32'h9E37_79B1) ^ {a[15:0], a[31:16]} ^ 32'hC0DE_5EED;
    endfunction

    function automatic int bhtSlot(fetchPkg::addrT a);
        return int'(a[$clog2(`BHT_ENTRIES)+1:2]);
    endfunction

    function automatic int cacheSlot(fetchPkg::addrT a);
        return int'(a[$clog2(`ICACHE_LINES)+1:2]);
    endfunction

    function automatic logic modelTaken(fetchPkg::addrT a);
        int s;
        s = bhtSlot(a);
        return bhtValid[s] && (bhtPc[s] == a) && (bhtCtr[s] >= 2'd2);
    endfunction

    task automatic applyResolve(fetchPkg::addrT rpc, logic taken, fetchPkg::addrT tgt);
        int   s;
        logic match;
        s = bhtSlot(rpc);
        match = bhtValid[s] && (bhtPc[s] == rpc);
        if (!match)
            bhtCtr[s] = taken ? 2'd2 : 2'd1;
        else if (taken && bhtCtr[s] != 2'd3)
            bhtCtr[s] = bhtCtr[s] + 2'd1;
        else if (!taken && bhtCtr[s] != 2'd0)
            bhtCtr[s] = bhtCtr[s] - 2'd1;
        if (!match || taken)
            bhtTarget[s] = tgt;
        bhtValid[s] = 1'b1;
        bhtPc[s] = rpc;
    endtask

    task automatic reportError(int id, logic [31:0] expected, logic [31:0] actual);
        errCnt[id]++;
        $display("ERROR %s: expected %h, actual %h", testName[id], expected, actual);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Per-cycle checks, outputs sampled before this edge updates them
    ////////////////////////////////////////////////////////////////////////////

    task automatic checkOutputs();
        logic [99:0] curOut;
        logic        guess;
        int          slot;
        curOut = {ir, instrAddr, pc, fetchValid, predictTaken, predictCtr};
        // A redirect shows up two edges after it is driven
        if (redirPrev) begin
            expectNext = redirPrevAddr;
            expectSrc = TestRedirect;
        end
        if (flushPrev) begin
            chkCnt[TestFlush]++;
            if (fetchValid !== 1'b0)
                reportError(TestFlush, 32'd0, 32'(fetchValid));
        end else if (stallPrev) begin
            chkCnt[TestStall]++;
            if (curOut !== lastOut) begin
                errCnt[TestStall]++;
                $display("ERROR %s: expected %h, actual %h", testName[TestStall], lastOut,
                         curOut);
            end
        end else begin
            if (missPrev) begin
                chkCnt[TestMiss]++;
                if (fetchValid !== 1'b0)
                    reportError(TestMiss, 32'd0, 32'(fetchValid));
            end
            if (fetchValid === 1'b1) begin
                slot = bhtSlot(instrAddr);
                guess = modelTaken(instrAddr);
                chkCnt[TestRead]++;
                if (ir !== memWord(instrAddr))
                    reportError(TestRead, memWord(instrAddr), ir);
                if (pc !== instrAddr + 32'd4)
                    reportError(TestRead, instrAddr + 32'd4, pc);
                chkCnt[expectSrc]++;
                if (instrAddr !== expectNext)
                    reportError(expectSrc, expectNext, instrAddr);
                chkCnt[TestPredict]++;
                if ({predictTaken, predictCtr} !== {guess, bhtCtr[slot]})
                    reportError(TestPredict, 32'({guess, bhtCtr[slot]}),
                                32'({predictTaken, predictCtr}));
                expectNext = guess ? bhtTarget[slot] : instrAddr + 32'd4;
                expectSrc = guess ? TestPredict : TestRead;
                if (iter >= RandomCycles)
                    drained++;
            end
        end
        if (resPrev)
            applyResolve(resPrevPc, resPrevTaken, resPrevTarget);
        // No refill for a word that is still in the cache
        if (memReq && !reqPrev) begin
            chkCnt[TestMiss]++;
            slot = cacheSlot(memAddr);
            if (cacheValid[slot] && cacheAddr[slot] == memAddr)
                reportError(TestMiss, 32'd0, 32'(memReq));
            // Same fetch address as the one that started the refill
            if (!redirPrev && iMiss !== 1'b1)
                reportError(TestMiss, 32'd1, 32'(iMiss));
        end
        stallPrev = ifIdStall;
        flushPrev = ifIdFlush;
        redirPrev = flushPipeAndPc;
        redirPrevAddr = redirectAddr;
        resPrev = resolveValid;
        resPrevPc = resolvePc;
        resPrevTaken = resolveTaken;
        resPrevTarget = resolveTarget;
        missPrev = iMiss;
        reqPrev = memReq;
        lastOut = curOut;
    endtask

    // Memory answers after 1 to WorstMissDelay cycles with one pulse
    task automatic answerMemory();
        int slot;
        if (memValid) begin
            memValid <= 1'b0;
        end else if (memReq) begin
            if (memWait == 0)
                memWait = 1 + {$random(seed)} % WorstMissDelay;
            memWait = memWait - 1;
            if (memWait == 0) begin
                slot = cacheSlot(memAddr);
                memValid <= 1'b1;
                memData <= memWord(memAddr);
                cacheValid[slot] = 1'b1;
                cacheAddr[slot] = memAddr;
            end
        end
    endtask

    task automatic driveInputs(logic active);
        logic stallNow;
        logic flushNow;
        // Stalls tend to last a few cycles
        stallNow = active && ({$random(seed)} % 100 < (pcStall ? 60 : 10));
        flushNow = active && ({$random(seed)} % 100 < 4);
        pcStall        <= stallNow;
        ifIdStall      <= stallNow && {$random(seed)} % 2 == 0;
        ifIdFlush      <= (stallNow || flushNow) && {$random(seed)} % 4 == 0;
        flushPipeAndPc <= flushNow;
        redirectAddr   <= ({$random(seed)} % AddrWords) * 4;
        resolveValid   <= active && {$random(seed)} % 100 < 15;
        resolvePc      <= ({$random(seed)} % AddrWords) * 4;
        resolveTaken   <= {$random(seed)} % 100 < 70;
        resolveTarget  <= ({$random(seed)} % AddrWords) * 4;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        seed = 75295;
        Clk = 1'b0;
        rstN = 1'b0;
        memValid = 1'b0;
        memData = '0;
        for (int i = 0; i < 6; i++) begin
            chkCnt[i] = 0;
            errCnt[i] = 0;
        end
        for (int i = 0; i < `BHT_ENTRIES; i++) begin
            bhtValid[i] = 1'b0;
            bhtCtr[i] = 2'd1;
        end
        for (int i = 0; i < `ICACHE_LINES; i++)
            cacheValid[i] = 1'b0;
        driveInputs(1'b0);
        repeat (8) @(posedge Clk);
        rstN <= 1'b1;
        // Quiet drain at the end proves the stage still makes progress
        while (iter < RandomCycles || drained < DrainOutputs) begin
            @(posedge Clk);
            checkOutputs();
            answerMemory();
            driveInputs(iter < RandomCycles);
            iter++;
        end
        for (int i = 0; i < 6; i++) begin
            $display("Test %s: %0d checks, %0d errors", testName[i], chkCnt[i], errCnt[i]);
            if (chkCnt[i] == 0) begin
                $display("Test %s never reached a check", testName[i]);
                errCnt[i]++;
            end
            totalChk += chkCnt[i];
            totalErr += errCnt[i];
        end
        $display("Checks %0d, errors %0d, cycles %0d", totalChk, totalErr, cycleCount);
        if (totalErr == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+.
fetchPkg.sv
pcUnit.sv
branchPredictor.sv
instrCache.sv
refillCtrl.sv
ifIdReg.sv
fetchStage.sv
fetchStageTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= fetchStageTb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard *.svh)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q '^STATUS: PASS$$'

clean:
	rm -rf $(BUILD_DIR)
